//--- Makefile
SOURCES := $(shell grep -v '^+' project.f)

.PHONY: all run clean

all: obj_dir/Vtb_rocache

obj_dir/Vtb_rocache: project.f $(SOURCES) common/rocache_consts.svh
	verilator --binary --timing -Wno-fatal --top-module tb_rocache \
	  -f project.f -o Vtb_rocache

run: obj_dir/Vtb_rocache
	./obj_dir/Vtb_rocache 2>&1 | tee sim.log
	@if grep -q "test failed" sim.log; then exit 1; fi
	@grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- cache/rocache_lookup.sv
`timescale 1ns/1ns
`include "rocache_consts.svh"

module rocache_lookup
  import rocache_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        flush_valid_i,
  output logic        flush_ready_o,
  input  core_req_t   req_i,
  output core_rsp_t   hit_rsp_o,
  output core_req_t   miss_o,
  input  line_write_t line_write_i
);

  // Arrays
  logic [`ROCACHE_TAG_W-1:0]      tag_mem [`ROCACHE_LINE_COUNT];
  line_t                          data_mem [`ROCACHE_LINE_COUNT];
  logic [`ROCACHE_LINE_COUNT-1:0] valid_q;

  addr_fields_t               req_f;
  logic                       lookup_hit;
  logic                       miss_busy_q;
  logic                       hit_valid_q;
  logic [`ROCACHE_DATA_W-1:0] hit_data_q;
  logic                       miss_valid_q;
  addr_u                      miss_addr_q;

  assign req_f = req_i.addr.fields;
  assign lookup_hit = valid_q[req_f.index] && (tag_mem[req_f.index] == req_f.tag);

  // No flush while a refill is on its way into the arrays
  assign flush_ready_o = !miss_busy_q;

  // ------------------------------------------------------------
  // Control state
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      hit_valid_q  <= 1'b0;
      miss_valid_q <= 1'b0;
      miss_busy_q  <= 1'b0;
      valid_q      <= '0;
    end else begin
      hit_valid_q  <= req_i.valid && lookup_hit;
      miss_valid_q <= req_i.valid && !lookup_hit;
      if (req_i.valid && !lookup_hit) begin
        miss_busy_q <= 1'b1;
      end else if (line_write_i.valid) begin
        miss_busy_q <= 1'b0;
      end
      if (line_write_i.valid) begin
        valid_q[line_write_i.index] <= 1'b1;
      end
      // Whole cache invalid in one cycle
      if (flush_valid_i && flush_ready_o) begin
        valid_q <= '0;
      end
    end
  end

  // ------------------------------------------------------------
  // Tag and data arrays, result payload
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    hit_data_q  <= data_mem[req_f.index][req_f.offset];
    miss_addr_q <= req_i.addr;
    if (line_write_i.valid) begin
      tag_mem[line_write_i.index]  <= line_write_i.tag;
      data_mem[line_write_i.index] <= line_write_i.line;
    end
  end

  assign hit_rsp_o.valid = hit_valid_q;
  assign hit_rsp_o.data  = hit_data_q;
  assign miss_o.valid    = miss_valid_q;
  assign miss_o.addr     = miss_addr_q;

endmodule

//--- cache/rocache_miss_handler.sv
`timescale 1ns/1ns
`include "rocache_consts.svh"

module rocache_miss_handler
  import rocache_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  core_req_t   miss_i,
  output mem_req_t    mem_req_o,
  input  logic        mem_req_ready_i,
  input  mem_rsp_t    mem_rsp_i,
  output line_write_t line_write_o,
  output core_rsp_t   rsp_o
);

  localparam logic [`ROCACHE_OFFSET_W-1:0] LastWord =
    `ROCACHE_OFFSET_W'(`ROCACHE_LINE_WORDS - 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FETCH,
    ST_DONE
  } state_e;

  state_e                        state_q;
  logic [`ROCACHE_OFFSET_W-1:0]  req_cnt_q;
  logic [`ROCACHE_OFFSET_W-1:0]  rsp_cnt_q;
  logic                          req_done_q;
  addr_u                         miss_addr_q;
  line_t                         line_buf_q;

  // ------------------------------------------------------------
  // Fetch sequencing
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= ST_IDLE;
      req_cnt_q  <= '0;
      rsp_cnt_q  <= '0;
      req_done_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (miss_i.valid) begin
            state_q    <= ST_FETCH;
            req_cnt_q  <= '0;
            rsp_cnt_q  <= '0;
            req_done_q <= 1'b0;
          end
        end
        ST_FETCH: begin
          // Requests and returning words may overlap
          if (mem_req_o.valid && mem_req_ready_i) begin
            req_cnt_q <= req_cnt_q + 1'b1;
            if (req_cnt_q == LastWord) begin
              req_done_q <= 1'b1;
            end
          end
          if (mem_rsp_i.valid) begin
            rsp_cnt_q <= rsp_cnt_q + 1'b1;
            if (rsp_cnt_q == LastWord) begin
              state_q <= ST_DONE;
            end
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && miss_i.valid) begin
      miss_addr_q <= miss_i.addr;
    end
    if (state_q == ST_FETCH && mem_rsp_i.valid) begin
      line_buf_q[rsp_cnt_q] <= mem_rsp_i.data;
    end
  end

  // Line-aligned fetch, word by word
  assign mem_req_o.valid              = (state_q == ST_FETCH) && !req_done_q;
  assign mem_req_o.addr.fields.tag    = miss_addr_q.fields.tag;
  assign mem_req_o.addr.fields.index  = miss_addr_q.fields.index;
  assign mem_req_o.addr.fields.offset = req_cnt_q;

  // Line write and response go out together
  assign line_write_o.valid = (state_q == ST_DONE);
  assign line_write_o.index = miss_addr_q.fields.index;
  assign line_write_o.tag   = miss_addr_q.fields.tag;
  assign line_write_o.line  = line_buf_q;

  assign rsp_o.valid = (state_q == ST_DONE);
  assign rsp_o.data  = line_buf_q[miss_addr_q.fields.offset];

endmodule

//--- common/rocache_consts.svh
`ifndef ROCACHE_CONSTS_SVH
`define ROCACHE_CONSTS_SVH

// Word address and data widths
`define ROCACHE_ADDR_W 16
`define ROCACHE_DATA_W 32

// Line geometry
`define ROCACHE_LINE_WORDS 4
`define ROCACHE_OFFSET_W 2

// Direct-mapped array size
`define ROCACHE_LINE_COUNT 16
`define ROCACHE_INDEX_W 4

// Whatever is left of the address above index and offset
`define ROCACHE_TAG_W 10

// Configuration register select
`define ROCACHE_CFG_SEL_W 2

`endif

//--- common/rocache_pkg.sv
package rocache_pkg;

  `include "rocache_consts.svh"

  // Address split as seen by the cache arrays
  typedef struct packed {
    logic [`ROCACHE_TAG_W-1:0]    tag;
    logic [`ROCACHE_INDEX_W-1:0]  index;
    logic [`ROCACHE_OFFSET_W-1:0] offset;
  } addr_fields_t;

  // Router compares raw words, cache modules decode fields
  typedef union packed {
    logic [`ROCACHE_ADDR_W-1:0] raw;
    addr_fields_t               fields;
  } addr_u;

  typedef struct packed {
    logic  valid;
    addr_u addr;
  } core_req_t;

  typedef struct packed {
    logic                       valid;
    logic [`ROCACHE_DATA_W-1:0] data;
  } core_rsp_t;

  typedef struct packed {
    logic  valid;
    addr_u addr;
  } mem_req_t;

  typedef struct packed {
    logic                       valid;
    logic [`ROCACHE_DATA_W-1:0] data;
  } mem_rsp_t;

  typedef struct packed {
    logic                       enable;
    logic [`ROCACHE_ADDR_W-1:0] start_addr;
    logic [`ROCACHE_ADDR_W-1:0] end_addr;
  } region_cfg_t;

  typedef logic [`ROCACHE_LINE_WORDS-1:0][`ROCACHE_DATA_W-1:0] line_t;

  typedef struct packed {
    logic                        valid;
    logic [`ROCACHE_INDEX_W-1:0] index;
    logic [`ROCACHE_TAG_W-1:0]   tag;
    line_t                       line;
  } line_write_t;

  typedef enum logic {
    PATH_BYPASS = 1'b0,
    PATH_CACHE  = 1'b1
  } path_e;

endpackage

//--- design/rocache_cfg_regs.sv
`timescale 1ns/1ns
`include "rocache_consts.svh"

module rocache_cfg_regs
  import rocache_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          cfg_we_i,
  input  logic [`ROCACHE_CFG_SEL_W-1:0] cfg_sel_i,
  input  logic [`ROCACHE_ADDR_W-1:0]    cfg_wdata_i,
  output region_cfg_t                   region_cfg_o
);

  // Register map
  localparam logic [`ROCACHE_CFG_SEL_W-1:0] SelEnable = 2'd0;
  localparam logic [`ROCACHE_CFG_SEL_W-1:0] SelStart  = 2'd1;
  localparam logic [`ROCACHE_CFG_SEL_W-1:0] SelEnd    = 2'd2;

  region_cfg_t region_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      region_q <= '0;
    end else if (cfg_we_i) begin
      case (cfg_sel_i)
        SelEnable: begin
          // Only bit 0 matters for the enable
          region_q.enable <= cfg_wdata_i[0];
        end
        SelStart: begin
          region_q.start_addr <= cfg_wdata_i;
        end
        SelEnd: begin
          region_q.end_addr <= cfg_wdata_i;
        end
        default: begin
          // Select 3 has no register behind it
          region_q <= region_q;
        end
      endcase
    end
  end

  assign region_cfg_o = region_q;

endmodule

//--- design/rocache_router.sv
`timescale 1ns/1ns
`include "rocache_consts.svh"

module rocache_router
  import rocache_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  region_cfg_t region_cfg_i,
  input  core_req_t   core_req_i,
  output logic        core_req_ready_o,
  output core_rsp_t   core_rsp_o,
  input  logic        core_rsp_ready_i,
  output core_req_t   cache_req_o,
  input  core_rsp_t   hit_rsp_i,
  input  mem_req_t    refill_req_i,
  output logic        refill_req_ready_o,
  output mem_rsp_t    refill_rsp_o,
  input  core_rsp_t   handler_rsp_i,
  output mem_req_t    mem_req_o,
  input  logic        mem_req_ready_i,
  input  mem_rsp_t    mem_rsp_i
);

  logic                       busy_q;
  path_e                      path_q;
  path_e                      req_path;
  logic                       accept;
  logic                       in_region;
  logic                       byp_pend_q;
  addr_u                      byp_addr_q;
  logic                       rsp_valid_q;
  logic [`ROCACHE_DATA_W-1:0] rsp_data_q;
  logic                       rsp_capture;
  logic [`ROCACHE_DATA_W-1:0] rsp_data_d;

  // ------------------------------------------------------------
  // Region decision
  // ------------------------------------------------------------
  assign core_req_ready_o = !busy_q;
  assign accept = core_req_i.valid && core_req_ready_o;

  // Start bound inside, end bound outside
  assign in_region = region_cfg_i.enable &&
                     (region_cfg_i.start_addr <= core_req_i.addr.raw) &&
                     (core_req_i.addr.raw < region_cfg_i.end_addr);
  assign req_path = in_region ? PATH_CACHE : PATH_BYPASS;

  assign cache_req_o.valid = accept && (req_path == PATH_CACHE);
  assign cache_req_o.addr  = core_req_i.addr;

  // ------------------------------------------------------------
  // Memory port sharing
  // ------------------------------------------------------------
  always_comb begin
    if (path_q == PATH_CACHE) begin
      mem_req_o = refill_req_i;
    end else begin
      mem_req_o.valid = byp_pend_q;
      mem_req_o.addr  = byp_addr_q;
    end
  end

  assign refill_req_ready_o = mem_req_ready_i && (path_q == PATH_CACHE);
  assign refill_rsp_o.valid = mem_rsp_i.valid && (path_q == PATH_CACHE);
  assign refill_rsp_o.data  = mem_rsp_i.data;

  // ------------------------------------------------------------
  // Response capture
  // ------------------------------------------------------------
  always_comb begin
    rsp_capture = 1'b0;
    rsp_data_d  = mem_rsp_i.data;
    if (path_q == PATH_CACHE) begin
      if (hit_rsp_i.valid) begin
        rsp_capture = 1'b1;
        rsp_data_d  = hit_rsp_i.data;
      end else if (handler_rsp_i.valid) begin
        rsp_capture = 1'b1;
        rsp_data_d  = handler_rsp_i.data;
      end
    end else if (busy_q && mem_rsp_i.valid) begin
      // Only one read outstanding, so this is the bypass answer
      rsp_capture = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q      <= 1'b0;
      path_q      <= PATH_BYPASS;
      byp_pend_q  <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      if (accept) begin
        busy_q     <= 1'b1;
        path_q     <= req_path;
        byp_pend_q <= (req_path == PATH_BYPASS);
      end else if (rsp_valid_q && core_rsp_ready_i) begin
        busy_q <= 1'b0;
      end
      if (byp_pend_q && mem_req_ready_i) begin
        byp_pend_q <= 1'b0;
      end
      if (rsp_capture) begin
        rsp_valid_q <= 1'b1;
      end else if (core_rsp_ready_i) begin
        rsp_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      byp_addr_q <= core_req_i.addr;
    end
    if (rsp_capture) begin
      rsp_data_q <= rsp_data_d;
    end
  end

  assign core_rsp_o.valid = rsp_valid_q;
  assign core_rsp_o.data  = rsp_data_q;

endmodule

//--- design/rocache_top.sv
`timescale 1ns/1ns
`include "rocache_consts.svh"

module rocache_top
  import rocache_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          cfg_we_i,
  input  logic [`ROCACHE_CFG_SEL_W-1:0] cfg_sel_i,
  input  logic [`ROCACHE_ADDR_W-1:0]    cfg_wdata_i,
  input  logic                          flush_valid_i,
  output logic                          flush_ready_o,
  input  core_req_t                     core_req_i,
  output logic                          core_req_ready_o,
  output core_rsp_t                     core_rsp_o,
  input  logic                          core_rsp_ready_i,
  output mem_req_t                      mem_req_o,
  input  logic                          mem_req_ready_i,
  input  mem_rsp_t                      mem_rsp_i
);

  region_cfg_t region_cfg;
  core_req_t   cache_req;
  core_rsp_t   hit_rsp;
  core_req_t   miss_req;
  mem_req_t    refill_req;
  logic        refill_req_ready;
  mem_rsp_t    refill_rsp;
  core_rsp_t   handler_rsp;
  line_write_t line_write;

  rocache_cfg_regs u_cfg_regs (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cfg_we_i     (cfg_we_i),
    .cfg_sel_i    (cfg_sel_i),
    .cfg_wdata_i  (cfg_wdata_i),
    .region_cfg_o (region_cfg)
  );

  rocache_router u_router (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .region_cfg_i       (region_cfg),
    .core_req_i         (core_req_i),
    .core_req_ready_o   (core_req_ready_o),
    .core_rsp_o         (core_rsp_o),
    .core_rsp_ready_i   (core_rsp_ready_i),
    .cache_req_o        (cache_req),
    .hit_rsp_i          (hit_rsp),
    .refill_req_i       (refill_req),
    .refill_req_ready_o (refill_req_ready),
    .refill_rsp_o       (refill_rsp),
    .handler_rsp_i      (handler_rsp),
    .mem_req_o          (mem_req_o),
    .mem_req_ready_i    (mem_req_ready_i),
    .mem_rsp_i          (mem_rsp_i)
  );

  rocache_lookup u_lookup (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_valid_i (flush_valid_i),
    .flush_ready_o (flush_ready_o),
    .req_i         (cache_req),
    .hit_rsp_o     (hit_rsp),
    .miss_o        (miss_req),
    .line_write_i  (line_write)
  );

  rocache_miss_handler u_miss_handler (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .miss_i          (miss_req),
    .mem_req_o       (refill_req),
    .mem_req_ready_i (refill_req_ready),
    .mem_rsp_i       (refill_rsp),
    .line_write_o    (line_write),
    .rsp_o           (handler_rsp)
  );

endmodule

//--- project.f
+incdir+common
common/rocache_pkg.sv
design/rocache_cfg_regs.sv
design/rocache_router.sv
cache/rocache_lookup.sv
cache/rocache_miss_handler.sv
design/rocache_top.sv
testbench/tb_mem_model.sv
testbench/tb_rocache.sv

//--- testbench/tb_mem_model.sv
`timescale 1ns/1ns
`include "rocache_consts.svh"

module tb_mem_model
  import rocache_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic [7:0]  gen_i,
  input  logic [1:0]  rsp_delay_i,
  input  mem_req_t    mem_req_i,
  input  logic        mem_req_ready_i,
  output mem_rsp_t    mem_rsp_o,
  output logic [31:0] req_count_o
);

  logic [`ROCACHE_DATA_W-1:0] data_q[$];
  int                         due_q[$];
  int                         cycle;
  int                         last_due;
  int                         due;

  // Word content, the generation makes memory change
  function automatic logic [`ROCACHE_DATA_W-1:0] mem_word(
    input logic [`ROCACHE_ADDR_W-1:0] addr,
    input logic [7:0]                 gen
  );
    return {addr ^ 16'hC35A, gen, addr[15:8] ^ addr[7:0]};
  endfunction

  initial begin
    mem_rsp_o   = '0;
    req_count_o = '0;
    cycle       = 0;
    last_due    = 0;
    forever begin
      // Handshake is stable at the falling edge
      @(negedge clk_i);
      if (!rst_n_i) begin
        data_q.delete();
        due_q.delete();
        last_due = cycle;
      end else if (mem_req_i.valid && mem_req_ready_i) begin
        due = cycle + 2 + int'(rsp_delay_i);
        // Keep responses in order
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        data_q.push_back(mem_word(mem_req_i.addr.raw, gen_i));
        due_q.push_back(due);
        req_count_o = req_count_o + 32'd1;
      end
      @(posedge clk_i);
      cycle = cycle + 1;
      #2;
      if (due_q.size() > 0 && due_q[0] <= cycle) begin
        mem_rsp_o.valid = 1'b1;
        mem_rsp_o.data  = data_q.pop_front();
        void'(due_q.pop_front());
      end else begin
        mem_rsp_o = '0;
      end
    end
  end

endmodule

//--- testbench/tb_rocache.sv
`timescale 1ns/1ns
`include "rocache_consts.svh"

module tb_rocache
  import rocache_pkg::*;
();

  localparam int          CLK_PERIOD       = 40;
  localparam int          NUM_DIRECTED_OPS = 25;
  localparam int          NUM_RANDOM_OPS   = 200;
  localparam int          NUM_OPS          = NUM_DIRECTED_OPS + NUM_RANDOM_OPS;
  localparam logic [15:0] LFSR_SEED        = 16'd79;

  logic                          clk_i;
  logic                          rst_n_i;
  logic                          cfg_we_i;
  logic [`ROCACHE_CFG_SEL_W-1:0] cfg_sel_i;
  logic [`ROCACHE_ADDR_W-1:0]    cfg_wdata_i;
  logic                          flush_valid_i;
  logic                          flush_ready_o;
  core_req_t                     core_req_i;
  logic                          core_req_ready_o;
  core_rsp_t                     core_rsp_o;
  logic                          core_rsp_ready_i;
  mem_req_t                      mem_req_o;
  logic                          mem_req_ready_i;
  mem_rsp_t                      mem_rsp_i;
  logic [1:0]                    rsp_delay;
  logic [31:0]                   mem_req_count;

  logic [15:0]                lfsr_q;
  logic [7:0]                 gen;
  int                         issued;
  int                         rsp_count;
  int                         mem_total;
  logic [`ROCACHE_DATA_W-1:0] exp_data_q[$];
  int                         exp_reqs_q[$];

  // Shadow of the cache state and the configuration
  logic [`ROCACHE_LINE_COUNT-1:0] sh_valid;
  logic [`ROCACHE_TAG_W-1:0]      sh_tag [`ROCACHE_LINE_COUNT];
  logic [7:0]                     sh_gen [`ROCACHE_LINE_COUNT];
  logic                           sh_en;
  logic [`ROCACHE_ADDR_W-1:0]     sh_start;
  logic [`ROCACHE_ADDR_W-1:0]     sh_end;

  rocache_top u_dut (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .cfg_we_i         (cfg_we_i),
    .cfg_sel_i        (cfg_sel_i),
    .cfg_wdata_i      (cfg_wdata_i),
    .flush_valid_i    (flush_valid_i),
    .flush_ready_o    (flush_ready_o),
    .core_req_i       (core_req_i),
    .core_req_ready_o (core_req_ready_o),
    .core_rsp_o       (core_rsp_o),
    .core_rsp_ready_i (core_rsp_ready_i),
    .mem_req_o        (mem_req_o),
    .mem_req_ready_i  (mem_req_ready_i),
    .mem_rsp_i        (mem_rsp_i)
  );

  tb_mem_model u_mem (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .gen_i           (gen),
    .rsp_delay_i     (rsp_delay),
    .mem_req_i       (mem_req_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_rsp_o       (mem_rsp_i),
    .req_count_o     (mem_req_count)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // ------------------------------------------------------------
  // Random bits and the reference model
  // ------------------------------------------------------------
  function automatic logic lfsr_bit();
    logic out;
    out    = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (out) begin
      lfsr_q = lfsr_q ^ 16'hB400;
    end
    return out;
  endfunction

  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[14:0], lfsr_bit()};
    end
    return v;
  endfunction

  // Expected data of one read and the shadow update on a fill
  function automatic logic [`ROCACHE_DATA_W-1:0] expect_read(
    input  logic [`ROCACHE_ADDR_W-1:0] addr,
    output int                         reqs
  );
    logic [`ROCACHE_TAG_W-1:0]   tag;
    logic [`ROCACHE_INDEX_W-1:0] idx;
    tag = addr[`ROCACHE_ADDR_W-1 -: `ROCACHE_TAG_W];
    idx = addr[`ROCACHE_OFFSET_W +: `ROCACHE_INDEX_W];
    if (!(sh_en && sh_start <= addr && addr < sh_end)) begin
      reqs = 1;
      return u_mem.mem_word(addr, gen);
    end
    if (sh_valid[idx] && sh_tag[idx] == tag) begin
      reqs = 0;
      return u_mem.mem_word(addr, sh_gen[idx]);
    end
    sh_valid[idx] = 1'b1;
    sh_tag[idx]   = tag;
    sh_gen[idx]   = gen;
    reqs = `ROCACHE_LINE_WORDS;
    return u_mem.mem_word(addr, gen);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      $display("test failed");
      $fatal(1);
    end
  endtask

  // ------------------------------------------------------------
  // Stimulus tasks start and end just after a rising edge
  // ------------------------------------------------------------
  task automatic issue_read(input logic [`ROCACHE_ADDR_W-1:0] addr);
    logic [`ROCACHE_DATA_W-1:0] data;
    int                         reqs;
    data      = expect_read(addr, reqs);
    mem_total = mem_total + reqs;
    exp_data_q.push_back(data);
    exp_reqs_q.push_back(mem_total);
    issued = issued + 1;
    core_req_i.valid    = 1'b1;
    core_req_i.addr.raw = addr;
    do @(negedge clk_i); while (!core_req_ready_o);
    @(posedge clk_i);
    #2;
    core_req_i.valid = 1'b0;
    // Ready drops the cycle after an acceptance
    @(negedge clk_i);
    check_value("core_req_ready_o", core_req_ready_o, 1'b0);
    @(posedge clk_i);
    #2;
    while (rsp_count != issued) begin
      @(posedge clk_i);
      #2;
    end
  endtask

  task automatic write_cfg(input logic [1:0] sel, input logic [`ROCACHE_ADDR_W-1:0] data);
    cfg_we_i    = 1'b1;
    cfg_sel_i   = sel;
    cfg_wdata_i = data;
    @(posedge clk_i);
    #2;
    cfg_we_i = 1'b0;
    case (sel)
      2'd0: sh_en = data[0];
      2'd1: sh_start = data;
      2'd2: sh_end = data;
      default: ;
    endcase
  endtask

  task automatic flush_cache();
    flush_valid_i = 1'b1;
    // No miss is in progress between reads
    @(negedge clk_i);
    check_value("flush_ready_o", flush_ready_o, 1'b1);
    @(posedge clk_i);
    #2;
    flush_valid_i = 1'b0;
    sh_valid      = '0;
  endtask

  // Random readies and memory delay
  initial begin
    logic [15:0] rnd;
    core_rsp_ready_i = 1'b0;
    mem_req_ready_i  = 1'b0;
    rsp_delay        = 2'd0;
    forever begin
      @(negedge clk_i);
      rnd = rand_bits(6);
      @(posedge clk_i);
      #2;
      core_rsp_ready_i = |rnd[1:0];
      mem_req_ready_i  = |rnd[3:2];
      rsp_delay        = rnd[5:4];
    end
  end

  // Compare every accepted response with the queued expectation
  initial begin
    logic [`ROCACHE_DATA_W-1:0] exp_data;
    int                         exp_reqs;
    rsp_count = 0;
    forever begin
      @(negedge clk_i);
      if (rst_n_i && core_rsp_o.valid && core_rsp_ready_i) begin
        if (exp_data_q.size() == 0) begin
          $display("A core response arrived while no read was pending");
          $display("test failed");
          $fatal(1);
        end else begin
          exp_data = exp_data_q.pop_front();
          exp_reqs = exp_reqs_q.pop_front();
          check_value("core_rsp_o.data", core_rsp_o.data, exp_data);
          check_value("mem_req_count", mem_req_count, exp_reqs);
          rsp_count = rsp_count + 1;
        end
      end
    end
  end

  initial begin
    #(NUM_OPS * 200 * CLK_PERIOD);
    $display("Watchdog expired, the DUT stopped answering before all reads finished");
    $display("test failed");
    $fatal(1);
  end

  initial begin
    logic [15:0] rnd;
    lfsr_q        = LFSR_SEED;
    gen           = 8'd0;
    issued        = 0;
    mem_total     = 0;
    rst_n_i       = 1'b0;
    cfg_we_i      = 1'b0;
    cfg_sel_i     = '0;
    cfg_wdata_i   = '0;
    flush_valid_i = 1'b0;
    core_req_i    = '0;
    sh_valid      = '0;
    sh_en         = 1'b0;
    sh_start      = '0;
    sh_end        = '0;
    repeat (16) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;

    // With the cache disabled all reads go to memory
    issue_read(16'h0010);
    issue_read(16'h0123);
    gen = gen + 8'd1;
    issue_read(16'h0123);
    issue_read(16'h0333);

    // Region 0x0100 up to 0x0200
    write_cfg(2'd1, 16'h0100);
    write_cfg(2'd2, 16'h0200);
    write_cfg(2'd0, 16'h0001);
    issue_read(16'h0105);
    gen = gen + 8'd1;
    issue_read(16'h0106);
    issue_read(16'h0104);
    issue_read(16'h0107);

    // Bounds
    issue_read(16'h0100);
    issue_read(16'h00FF);
    issue_read(16'h0200);
    gen = gen + 8'd1;
    issue_read(16'h0100);
    issue_read(16'h0200);

    flush_cache();
    issue_read(16'h0105);

    // Same index and different tags
    issue_read(16'h0108);
    issue_read(16'h0148);
    issue_read(16'h0108);
    gen = gen + 8'd1;
    issue_read(16'h0148);
    issue_read(16'h0109);

    for (int n = 0; n < NUM_RANDOM_OPS; n++) begin
      rnd = rand_bits(4);
      if (rnd[3:0] == 4'd0) begin
        flush_cache();
      end else if (rnd[3:0] == 4'd1) begin
        rnd = rand_bits(12);
        write_cfg(rnd[11:10], {6'd0, rnd[9:0]});
      end else begin
        rnd = rand_bits(12);
        if (rnd[11:10] == 2'd0) begin
          gen = gen + 8'd1;
        end
        issue_read({6'd0, rnd[9:0]});
      end
    end

    // Memory stays quiet once the last read is answered
    repeat (10) @(posedge clk_i);
    if (mem_req_count !== mem_total) begin
      check_value("mem_req_count", mem_req_count, mem_total);
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule
